/* hdl/parse_cfg.svh */
`ifndef PARSE_CFG_SVH
`define PARSE_CFG_SVH

// ==============================
// Sprite Y-parse configuration
// ==============================

// Sprites examined per clock
// Power of two, one table bank per lane
`define LANES 4

// Entries in the sprite attribute table
// Multiple of LANES, gives SPRITE_COUNT / LANES groups
`define SPRITE_COUNT 384

// ==============================
// Active list
// ==============================

// Capacity of the active list
// Matching sprites past this count are dropped
`define LIST_DEPTH 96

`endif

/* hdl/spriteParsePkg.sv */
package spriteParsePkg;

	// ==============================
	// Widths
	// ==============================

	// Index into the sprite attribute table
	typedef logic [8:0] spriteIdx_t;

	// Y attribute word
	// [15:7] Y position, [6] chain, [5:0] size with [5] full height
	typedef logic [15:0] yWord_t;

	// Raster line number
	typedef logic [8:0] lineNum_t;

	// Active list address, also used as the entry count
	typedef logic [6:0] listAddr_t;

	// Lane group number, one group holds LANES sprites
	typedef logic [6:0] groupIdx_t;

	// ==============================
	// Fetch FSM
	// ==============================

	// IDLE is the first cycle after line start
	typedef enum logic [1:0] {
		IDLE,
		PARSE,
		DONE
	} fetchState_t;

endpackage

/* hdl/parseIf.sv */
// ==============================
// Fetch to match lane
// ==============================

interface laneInIf;
	import spriteParsePkg::*;

	// Word of this lane's sprite is present
	logic valid;
	// Raw Y attribute word
	yWord_t yWord;
	// Raster line after the flip inversion
	lineNum_t effLine;
	// Set on the final group of the table
	logic lastGroup;

	modport fetch (output valid, output yWord, output effLine, output lastGroup);
	modport lane (input valid, input yWord, input effLine, input lastGroup);
endinterface

// ==============================
// Match lane to list writer
// ==============================

interface laneOutIf;
	// Result of this lane is present
	logic valid;
	// Own Y/size match, before chain resolution
	logic match;
	// Chain bit of the sprite
	logic chain;
	// Delayed copy of the last-group marker
	logic lastGroup;

	modport lane (output valid, output match, output chain, output lastGroup);
	modport writer (input valid, input match, input chain, input lastGroup);
endinterface

/* hdl/spriteTableFetch.sv */
`include "parse_cfg.svh"

module spriteTableFetch (
	input  logic                      CLK_24M,
	input  logic                      nNEW_LINE,
	input  spriteParsePkg::lineNum_t  rasterLine,
	input  logic                      flip,
	input  logic                      cpuWe,
	input  spriteParsePkg::spriteIdx_t cpuAddr,
	input  spriteParsePkg::yWord_t    cpuData,
	laneInIf.fetch                    lanes [`LANES]
);
	import spriteParsePkg::*;

	localparam int GROUPS = `SPRITE_COUNT / `LANES;
	localparam int LANE_BITS = $clog2(`LANES);
	localparam groupIdx_t LAST_GROUP = groupIdx_t'(GROUPS - 1);

	fetchState_t state;
	groupIdx_t groupCnt;
	logic feedValid;
	logic feedLast;
	lineNum_t effLine;

	logic [LANE_BITS-1:0] cpuBank;
	groupIdx_t cpuRow;
	logic cpuInRange;

	// ==============================
	// CPU write decode
	// ==============================

	// Low index bits pick the bank, upper bits the row
	assign cpuBank = cpuAddr[LANE_BITS-1:0];
	assign cpuRow = groupIdx_t'(cpuAddr >> LANE_BITS);
	// Writes past the table end are ignored
	assign cpuInRange = cpuAddr < spriteIdx_t'(`SPRITE_COUNT);

	// ==============================
	// Group walk
	// ==============================

	always_ff @(posedge CLK_24M or negedge nNEW_LINE)
	begin
		if (!nNEW_LINE)
		begin
			state <= IDLE;
			groupCnt <= '0;
			feedValid <= 1'b0;
			feedLast <= 1'b0;
		end
		else
		begin
			// One group read per cycle until the table is exhausted
			feedValid <= (state != DONE);
			feedLast <= (state != DONE) && (groupCnt == LAST_GROUP);
			case (state)
				IDLE:
				begin
					// Group 0 is read on this edge
					state <= PARSE;
					groupCnt <= groupCnt + 1'b1;
				end
				PARSE:
				begin
					if (groupCnt == LAST_GROUP)
						state <= DONE;
					else
						groupCnt <= groupCnt + 1'b1;
				end
				default:
				begin
					// Hold until the next line start
					state <= DONE;
				end
			endcase
		end
	end

	// Line seen by the lanes
	// Flip mirrors the raster vertically
	always_ff @(posedge CLK_24M)
		effLine <= flip ? ~rasterLine : rasterLine;

	// ==============================
	// Table banks and lane feed
	// ==============================

	for (genvar b = 0; b < `LANES; b++)
	begin : gBank
		// Sprites whose index modulo LANES equals b
		yWord_t mem [GROUPS];
		yWord_t rdWord;

		always_ff @(posedge CLK_24M)
		begin
			if (cpuWe && cpuInRange && (cpuBank == LANE_BITS'(b)))
				mem[cpuRow] <= cpuData;
			// Registered read, address is the current group
			rdWord <= mem[groupCnt];
		end

		assign lanes[b].valid = feedValid;
		assign lanes[b].yWord = rdWord;
		assign lanes[b].effLine = effLine;
		assign lanes[b].lastGroup = feedLast;
	end

endmodule

/* hdl/yMatchLane.sv */
module yMatchLane (
	input  logic CLK_24M,
	input  logic nNEW_LINE,
	laneInIf.lane  inPort,
	laneOutIf.lane outPort
);
	import spriteParsePkg::*;

	lineNum_t yPos;
	logic [5:0] size;
	lineNum_t lookSum;
	logic ownMatch;

	// ==============================
	// Y/size compare
	// ==============================

	// Attribute word fields
	assign yPos = inPort.yWord[15:7];
	assign size = inPort.yWord[5:0];

	// Lookahead sum, wraps modulo 512
	assign lookSum = inPort.effLine + yPos;

	// Tile row inside the sprite against height in tiles
	// Full-height bit overrides the compare
	assign ownMatch = size[5] | (lookSum[8:4] < size[4:0]);

	// Strobes
	always_ff @(posedge CLK_24M or negedge nNEW_LINE)
	begin
		if (!nNEW_LINE)
		begin
			outPort.valid <= 1'b0;
			outPort.lastGroup <= 1'b0;
		end
		else
		begin
			outPort.valid <= inPort.valid;
			outPort.lastGroup <= inPort.valid & inPort.lastGroup;
		end
	end

	// Result payload
	// Chain is passed on, resolved later in index order
	always_ff @(posedge CLK_24M)
	begin
		outPort.match <= ownMatch;
		outPort.chain <= inPort.yWord[6];
	end

endmodule

/* hdl/activeListWriter.sv */
`include "parse_cfg.svh"

module activeListWriter (
	input  logic                       CLK_24M,
	input  logic                       nNEW_LINE,
	laneOutIf.writer                   lanes [`LANES],
	input  spriteParsePkg::listAddr_t  listRdAddr,
	output spriteParsePkg::spriteIdx_t listRdData,
	output spriteParsePkg::listAddr_t  listCount,
	output logic                       listFull,
	output logic                       parseDone
);
	import spriteParsePkg::*;

	localparam int LANE_BITS = $clog2(`LANES);
	localparam listAddr_t DEPTH = listAddr_t'(`LIST_DEPTH);

	logic [`LANES-1:0] laneValid;
	logic [`LANES-1:0] laneMatch;
	logic [`LANES-1:0] laneChain;
	logic [`LANES-1:0] laneLast;
	logic groupValid;
	logic groupLast;

	// Active state of the last sprite of the previous group
	logic prevActive;
	groupIdx_t groupCnt;

	logic [`LANES-1:0] active;
	logic [`LANES-1:0] wrEn;
	spriteIdx_t laneIdx [`LANES];
	listAddr_t wrPos [`LANES];
	listAddr_t nextCount;

	// Active list storage
	spriteIdx_t list [`LIST_DEPTH];

	// ==============================
	// Lane unpack
	// ==============================

	for (genvar k = 0; k < `LANES; k++)
	begin : gLane
		assign laneValid[k] = lanes[k].valid;
		assign laneMatch[k] = lanes[k].match;
		assign laneChain[k] = lanes[k].chain;
		assign laneLast[k] = lanes[k].lastGroup;
		// Sprite index is group number then lane number
		assign laneIdx[k] = {groupCnt, LANE_BITS'(k)};
	end

	// All lanes run in lockstep
	assign groupValid = &laneValid;
	assign groupLast = &laneLast;

	// ==============================
	// Chain ripple and compaction
	// ==============================

	always_comb
	begin
		logic carry;
		listAddr_t pos;

		carry = prevActive;
		pos = listCount;
		for (int k = 0; k < `LANES; k++)
		begin
			// Chained sprite takes the decision of its predecessor
			active[k] = laneMatch[k] | (laneChain[k] & carry);
			carry = active[k];
			// Next free slot, stops advancing once full
			wrPos[k] = pos;
			wrEn[k] = groupValid & active[k] & (pos < DEPTH);
			if (wrEn[k])
				pos = pos + 1'b1;
		end
		nextCount = pos;
	end

	// Per-line control state
	always_ff @(posedge CLK_24M or negedge nNEW_LINE)
	begin
		if (!nNEW_LINE)
		begin
			// Sprite 0 sees an inactive predecessor
			prevActive <= 1'b0;
			groupCnt <= '0;
			listCount <= '0;
			listFull <= 1'b0;
			parseDone <= 1'b0;
		end
		else if (groupValid)
		begin
			prevActive <= active[`LANES-1];
			groupCnt <= groupCnt + 1'b1;
			listCount <= nextCount;
			listFull <= (nextCount == DEPTH);
			// Sticky until the next line
			if (groupLast)
				parseDone <= 1'b1;
		end
	end

	// Up to LANES entries per cycle, slots never overlap
	always_ff @(posedge CLK_24M)
	begin
		for (int k = 0; k < `LANES; k++)
		begin
			if (wrEn[k])
				list[wrPos[k]] <= laneIdx[k];
		end
	end

	// ==============================
	// Read port
	// ==============================

	// Combinational, out-of-range addresses read 0
	assign listRdData = (listRdAddr < DEPTH) ? list[listRdAddr] : '0;

endmodule

/* hdl/spriteParser.sv */
`include "parse_cfg.svh"

module spriteParser (
	input  logic                       CLK_24M,
	input  logic                       nNEW_LINE,
	input  spriteParsePkg::lineNum_t   rasterLine,
	input  logic                       flip,
	input  logic                       cpuWe,
	input  spriteParsePkg::spriteIdx_t cpuAddr,
	input  spriteParsePkg::yWord_t     cpuData,
	input  spriteParsePkg::listAddr_t  listRdAddr,
	output spriteParsePkg::spriteIdx_t listRdData,
	output spriteParsePkg::listAddr_t  listCount,
	output logic                       listFull,
	output logic                       parseDone
);

	// ==============================
	// Lane links
	// ==============================

	// Fetch feed, one per lane
	laneInIf laneIn [`LANES] ();
	// Match results, one per lane
	laneOutIf laneOut [`LANES] ();

	// Table, CPU port and group walk
	spriteTableFetch uFetch (
		.CLK_24M   (CLK_24M),
		.nNEW_LINE (nNEW_LINE),
		.rasterLine(rasterLine),
		.flip      (flip),
		.cpuWe     (cpuWe),
		.cpuAddr   (cpuAddr),
		.cpuData   (cpuData),
		.lanes     (laneIn)
	);

	// ==============================
	// Match lanes
	// ==============================

	for (genvar k = 0; k < `LANES; k++)
	begin : gMatch
		// Sprite k of every group
		yMatchLane uLane (
			.CLK_24M  (CLK_24M),
			.nNEW_LINE(nNEW_LINE),
			.inPort   (laneIn[k]),
			.outPort  (laneOut[k])
		);
	end

	// Chain resolution and active list
	activeListWriter uWriter (
		.CLK_24M   (CLK_24M),
		.nNEW_LINE (nNEW_LINE),
		.lanes     (laneOut),
		.listRdAddr(listRdAddr),
		.listRdData(listRdData),
		.listCount (listCount),
		.listFull  (listFull),
		.parseDone (parseDone)
	);

endmodule

/* tests/tbClock.sv */
module tbClock (
	output logic clk
);
	timeunit 1ns;
	timeprecision 1ps;

	// 24 MHz stand-in, 20 ns period
	initial
	begin
		clk = 1'b0;
		forever
			#10 clk = ~clk;
	end

endmodule

/* tests/spriteParser_properties.sv */
`include "parse_cfg.svh"

module activeListWriterProperties (
	input logic                      CLK_24M,
	input logic                      nNEW_LINE,
	input spriteParsePkg::listAddr_t listCount,
	input logic                      listFull,
	input logic                      parseDone
);
	timeunit 1ns;
	timeprecision 1ps;
	import spriteParsePkg::*;

	localparam listAddr_t DEPTH = listAddr_t'(`LIST_DEPTH);

	// ==============================
	// Per-line list state
	// ==============================

	// Count only grows within one line
	countGrows: assert property (@(posedge CLK_24M) disable iff (!nNEW_LINE)
		$past(nNEW_LINE) |-> listCount >= $past(listCount))
		else $error("listCount decreased during a parse");

	// Capacity bound
	countBounded: assert property (@(posedge CLK_24M) disable iff (!nNEW_LINE)
		listCount <= DEPTH)
		else $error("listCount beyond list capacity");

	// Full flag tracks the count exactly
	fullMatchesCount: assert property (@(posedge CLK_24M) disable iff (!nNEW_LINE)
		listFull == (listCount == DEPTH))
		else $error("listFull disagrees with listCount");

	// Done is sticky until the next line start
	doneSticky: assert property (@(posedge CLK_24M) disable iff (!nNEW_LINE)
		$past(nNEW_LINE) && $past(parseDone) |-> parseDone)
		else $error("parseDone dropped before reset");

endmodule

bind activeListWriter activeListWriterProperties uProps (
	.CLK_24M  (CLK_24M),
	.nNEW_LINE(nNEW_LINE),
	.listCount(listCount),
	.listFull (listFull),
	.parseDone(parseDone)
);

/* tests/tbSpriteParser.sv */
`include "parse_cfg.svh"

module tbSpriteParser;
	timeunit 1ns;
	timeprecision 1ps;
	import spriteParsePkg::*;

	// Edges from line release to parseDone
	localparam int PARSE_EDGES = `SPRITE_COUNT / `LANES + 2;
	localparam int PARSE_TIMEOUT = 4 * PARSE_EDGES;

	logic CLK_24M;
	logic nNEW_LINE;
	lineNum_t rasterLine;
	logic flip;
	logic cpuWe;
	spriteIdx_t cpuAddr;
	yWord_t cpuData;
	listAddr_t listRdAddr;
	spriteIdx_t listRdData;
	listAddr_t listCount;
	logic listFull;
	logic parseDone;

	// Table image and expected list
	yWord_t tableWords [`SPRITE_COUNT];
	int expList [`LIST_DEPTH];
	int expCount;
	int errorCount;
	int checkCount;
	integer seed;

	tbClock uClock (.clk(CLK_24M));

	spriteParser i_dut (.*);

	function automatic yWord_t makeWord(input int y, input logic chain, input int size);
		return {lineNum_t'(y), chain, 6'(size)};
	endfunction

	task automatic compareValue(input string testName, input int expected, input int actual);
		checkCount++;
		if (expected !== actual)
		begin
			errorCount++;
			$display("MISMATCH %s: expected %0d, actual %0d", testName, expected, actual);
		end
	endtask

	// ==============================
	// Reference model
	// ==============================

	task automatic computeExpected(input int line, input logic flipVal);
		lineNum_t eff;
		lineNum_t d;
		logic prev;
		logic act;

		eff = flipVal ? ~lineNum_t'(line) : lineNum_t'(line);
		prev = 1'b0;
		expCount = 0;
		for (int i = 0; i < `SPRITE_COUNT; i++)
		begin
			// Tile row of this line inside the sprite
			d = eff + tableWords[i][15:7];
			act = tableWords[i][5] || (d[8:4] < tableWords[i][4:0]);
			// Chained sprite follows its predecessor
			act = act || (tableWords[i][6] && prev);
			prev = act;
			if (act && expCount < `LIST_DEPTH)
			begin
				expList[expCount] = i;
				expCount++;
			end
		end
	endtask

	// ==============================
	// Load, parse and read back one line
	// ==============================

	task automatic runLine(input string testName, input int line, input logic flipVal);
		int cycles;

		@(posedge CLK_24M);
		#2;
		nNEW_LINE = 1'b0;
		rasterLine = lineNum_t'(line);
		flip = flipVal;
		// Whole table written while the line is held
		for (int i = 0; i < `SPRITE_COUNT; i++)
		begin
			cpuWe = 1'b1;
			cpuAddr = spriteIdx_t'(i);
			cpuData = tableWords[i];
			@(posedge CLK_24M);
			#2;
		end
		cpuWe = 1'b0;
		compareValue({testName, " count in reset"}, 0, int'(listCount));
		compareValue({testName, " full in reset"}, 0, int'(listFull));
		compareValue({testName, " done in reset"}, 0, int'(parseDone));
		nNEW_LINE = 1'b1;
		cycles = 0;
		while (!parseDone && cycles < PARSE_TIMEOUT)
		begin
			@(posedge CLK_24M);
			#2;
			cycles++;
		end
		if (!parseDone)
		begin
			$display("Timeout: parse never finished in test %s", testName);
			$display("Some tests failed");
			$finish;
		end
		else
		begin
			compareValue({testName, " done latency"}, PARSE_EDGES, cycles);
			computeExpected(line, flipVal);
			compareValue({testName, " count"}, expCount, int'(listCount));
			compareValue({testName, " full"}, int'(expCount == `LIST_DEPTH), int'(listFull));
			for (int i = 0; i < expCount; i++)
			begin
				@(posedge CLK_24M);
				#2;
				listRdAddr = listAddr_t'(i);
				#5;
				compareValue($sformatf("%s entry %0d", testName, i), expList[i],
					int'(listRdData));
			end
		end
	endtask

	task automatic clearTable();
		for (int i = 0; i < `SPRITE_COUNT; i++)
			tableWords[i] = '0;
	endtask

	// ==============================
	// Directed tests
	// ==============================

	// Two-tile and one-tile sprites at their edges on line 100
	task automatic testPlainMatch();
		clearTable();
		tableWords[3] = makeWord(412, 1'b0, 2);
		tableWords[10] = makeWord(443, 1'b0, 2);
		tableWords[11] = makeWord(444, 1'b0, 2);
		tableWords[20] = makeWord(411, 1'b0, 2);
		tableWords[150] = makeWord(428, 1'b0, 1);
		tableWords[200] = makeWord(412, 1'b0, 1);
		tableWords[383] = makeWord(427, 1'b0, 1);
		runLine("plainMatch", 100, 1'b0);
	endtask

	// Chains across group edges with dead leaders and a chained sprite 0
	task automatic testFullChain();
		clearTable();
		tableWords[0] = makeWord(0, 1'b1, 0);
		tableWords[1] = makeWord(0, 1'b1, 0);
		tableWords[5] = makeWord(300, 1'b0, 6'h20);
		for (int i = 6; i < 10; i++)
			tableWords[i] = makeWord(0, 1'b1, 0);
		tableWords[14] = makeWord(462, 1'b0, 1);
		tableWords[15] = makeWord(0, 1'b1, 0);
		tableWords[16] = makeWord(0, 1'b1, 0);
		tableWords[41] = makeWord(0, 1'b1, 0);
		tableWords[383] = makeWord(7, 1'b0, 6'h20);
		runLine("fullChain", 50, 1'b0);
	endtask

	task automatic testFlip();
		for (int i = 0; i < `SPRITE_COUNT; i++)
			tableWords[i] = makeWord((i * 37) % 512, logic'(i % 11 == 0), i % 3 + 1);
		runLine("flipOff", 40, 1'b0);
		runLine("flipOn", 40, 1'b1);
	endtask

	// Every sprite full height
	task automatic testFullList();
		for (int i = 0; i < `SPRITE_COUNT; i++)
			tableWords[i] = makeWord(i, 1'b0, 6'h20);
		runLine("fullList", 0, 1'b0);
	endtask

	task automatic testRandomLines();
		int line;
		logic flipVal;

		for (int n = 0; n < 4; n++)
		begin
			for (int i = 0; i < `SPRITE_COUNT; i++)
			begin
				tableWords[i] = yWord_t'($random(seed));
				// Full height kept rare
				tableWords[i][5] = (($random(seed) & 31) == 0);
			end
			line = $random(seed) & 511;
			flipVal = (($random(seed) & 1) != 0);
			runLine($sformatf("randomLine%0d", n), line, flipVal);
		end
	endtask

	initial
	begin
		errorCount = 0;
		checkCount = 0;
		seed = 24;
		nNEW_LINE = 1'b0;
		rasterLine = '0;
		flip = 1'b0;
		cpuWe = 1'b0;
		cpuAddr = '0;
		cpuData = '0;
		listRdAddr = '0;
		repeat (4) @(posedge CLK_24M);
		testPlainMatch();
		testFullChain();
		testFlip();
		testFullList();
		testRandomLines();
		$display("Checks run: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

/* tb.f */
+incdir+hdl
hdl/spriteParsePkg.sv
hdl/parseIf.sv
hdl/spriteTableFetch.sv
hdl/yMatchLane.sv
hdl/activeListWriter.sv
hdl/spriteParser.sv
tests/tbClock.sv
tests/spriteParser_properties.sv
tests/tbSpriteParser.sv

/* Makefile */
SIM := obj_dir/VtbSpriteParser
SOURCES := $(wildcard hdl/*.sv hdl/*.svh tests/*.sv)

$(SIM): tb.f $(SOURCES)
	verilator --binary --assert --timescale 1ns/1ps -f tb.f --top-module tbSpriteParser -Mdir obj_dir

run: $(SIM)
	./$(SIM) > sim.log 2>&1; status=$$?; cat sim.log; test $$status -eq 0
	! grep -q "Some tests failed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
